// File: hdl/mpm_params.svh
`ifndef MPM_PARAMS_SVH
`define MPM_PARAMS_SVH

// Data word.
`define MPM_WIDTH 32

// Virtual organisation of 4 banks by 16 rows gives 64 words.
`define MPM_NUMVBNK 4
`define MPM_NUMVROW 16

// One spare physical bank beyond the virtual ones.
`define MPM_NUMPBNK 5

// Two words packed per SRAM row.
`define MPM_NUMWRDS 2
`define MPM_NUMSROW 8

// Cycles from SRAM read enable to read data.
`define MPM_SRAM_DELAY 1

`endif

// File: hdl/mpm_pkg.sv
`default_nettype none

`include "mpm_params.svh"

package mpm_pkg;

  typedef logic [`MPM_WIDTH-1:0] word_t;
  typedef logic [$clog2(`MPM_NUMVBNK*`MPM_NUMVROW)-1:0] addr_t;

  typedef logic [$clog2(`MPM_NUMVBNK)-1:0] vbank_t;
  typedef logic [$clog2(`MPM_NUMPBNK)-1:0] pbank_t;
  typedef logic [$clog2(`MPM_NUMVROW)-1:0] vrow_t;
  typedef logic [$clog2(`MPM_NUMSROW)-1:0] srow_t;

  // One SRAM row holds NUMWRDS words side by side.
  typedef logic [`MPM_NUMWRDS*`MPM_WIDTH-1:0] phy_t;

  // Remap entry for one virtual row.
  typedef struct packed {
    pbank_t [`MPM_NUMVBNK-1:0] pb;   // Physical bank per virtual bank.
    pbank_t                    free; // Bank unused by this row.
  } map_row_t;

endpackage

`default_nettype wire

// File: hdl/mpm_wb_front.sv
`timescale 1ns/1ps
`default_nettype none

module mpm_wb_front (
  input  wire                 clk,
  input  wire                 rst_n,
  // Write port 0.
  input  wire                 w0_cyc,
  input  wire                 w0_stb,
  input  wire mpm_pkg::addr_t w0_adr,
  input  wire mpm_pkg::word_t w0_dat,
  output logic                w0_ack,
  // Write port 1.
  input  wire                 w1_cyc,
  input  wire                 w1_stb,
  input  wire mpm_pkg::addr_t w1_adr,
  input  wire mpm_pkg::word_t w1_dat,
  output logic                w1_ack,
  // Read port.
  input  wire                 r_cyc,
  input  wire                 r_stb,
  input  wire mpm_pkg::addr_t r_adr,
  output mpm_pkg::word_t      r_dat,
  output logic                r_ack,
  // Requests to the bank map.
  output logic                wr0_vld,
  output mpm_pkg::addr_t      wr0_adr,
  output mpm_pkg::word_t      wr0_dat,
  output logic                wr1_vld,
  output mpm_pkg::addr_t      wr1_adr,
  output mpm_pkg::word_t      wr1_dat,
  output logic                rd_req,
  output mpm_pkg::addr_t      rd_adr,
  input  wire                 rd_vld,
  input  wire mpm_pkg::word_t rd_dout
);

  logic w0_take;
  logic w1_take;
  logic r_take;
  logic rd_busy; // One read in flight.

  // A request is taken only when the previous one has fully retired.
  assign w0_take = w0_cyc && w0_stb && !wr0_vld && !w0_ack;
  assign w1_take = w1_cyc && w1_stb && !wr1_vld && !w1_ack;
  assign r_take  = r_cyc && r_stb && !rd_busy && !r_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr0_vld <= 1'b0;
      wr1_vld <= 1'b0;
      rd_req  <= 1'b0;
      w0_ack  <= 1'b0;
      w1_ack  <= 1'b0;
      r_ack   <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      wr0_vld <= w0_take;
      wr1_vld <= w1_take;
      w0_ack  <= wr0_vld; // Write completes with the SRAM update.
      w1_ack  <= wr1_vld;
      rd_req  <= r_take;
      r_ack   <= rd_vld;
      if (r_take) begin
        rd_busy <= 1'b1;
      end else if (rd_vld) begin
        rd_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w0_take) begin
      wr0_adr <= w0_adr;
      wr0_dat <= w0_dat;
    end
    if (w1_take) begin
      wr1_adr <= w1_adr;
      wr1_dat <= w1_dat;
    end
    if (r_take) begin
      rd_adr <= r_adr;
    end
    if (rd_vld) begin
      r_dat <= rd_dout; // Held for the ack cycle.
    end
  end

endmodule

`default_nettype wire

// File: hdl/mpm_bank_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpm_params.svh"

module mpm_bank_map (
  input  wire                 clk,
  input  wire                 rst_n,
  // Requests from the front end.
  input  wire                 wr0_vld,
  input  wire mpm_pkg::addr_t wr0_adr,
  input  wire mpm_pkg::word_t wr0_dat,
  input  wire                 wr1_vld,
  input  wire mpm_pkg::addr_t wr1_adr,
  input  wire mpm_pkg::word_t wr1_dat,
  input  wire                 rd_req,
  input  wire mpm_pkg::addr_t rd_adr,
  output logic                rd_vld,
  output mpm_pkg::word_t      rd_dout,
  // Per physical bank.
  output logic                bnk_write   [`MPM_NUMPBNK],
  output mpm_pkg::vrow_t      bnk_wr_row  [`MPM_NUMPBNK],
  output mpm_pkg::word_t      bnk_din     [`MPM_NUMPBNK],
  output logic                bnk_read    [`MPM_NUMPBNK],
  output mpm_pkg::vrow_t      bnk_rd_row  [`MPM_NUMPBNK],
  input  wire mpm_pkg::word_t bnk_rd_word [`MPM_NUMPBNK]
);

  import mpm_pkg::*;

  localparam int VB_W = $bits(vbank_t);

  map_row_t map_tbl [`MPM_NUMVROW];

  vbank_t wr0_vb;
  vrow_t  wr0_vr;
  vbank_t wr1_vb;
  vrow_t  wr1_vr;
  vbank_t rd_vb;
  vrow_t  rd_vr;
  pbank_t wr0_pb;
  pbank_t wr1_pb;
  pbank_t wr1_pb_sel; // Bank port 1 actually writes.
  pbank_t rd_pb;
  logic   wr_same;
  logic   wr_clash;
  logic   wr0_go;

  logic   rd_pipe_vld [`MPM_SRAM_DELAY];
  pbank_t rd_pipe_bnk [`MPM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address split and table lookup.
  assign wr0_vb = wr0_adr[VB_W-1:0];
  assign wr0_vr = vrow_t'(wr0_adr >> VB_W);
  assign wr1_vb = wr1_adr[VB_W-1:0];
  assign wr1_vr = vrow_t'(wr1_adr >> VB_W);
  assign rd_vb  = rd_adr[VB_W-1:0];
  assign rd_vr  = vrow_t'(rd_adr >> VB_W);

  assign wr0_pb = map_tbl[wr0_vr].pb[wr0_vb];
  assign wr1_pb = map_tbl[wr1_vr].pb[wr1_vb];
  assign rd_pb  = map_tbl[rd_vr].pb[rd_vb];

  // Port 1 wins a same-address write and port 0 is dropped.
  assign wr_same  = wr0_vld && wr1_vld && (wr0_adr == wr1_adr);
  assign wr_clash = wr0_vld && wr1_vld && !wr_same && (wr0_pb == wr1_pb);
  assign wr0_go   = wr0_vld && !wr_same;

  // Different addresses in one bank are always in different rows,
  // so port 1 can move into its own row's free bank.
  assign wr1_pb_sel = wr_clash ? map_tbl[wr1_vr].free : wr1_pb;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `MPM_NUMVROW; r++) begin
        for (int v = 0; v < `MPM_NUMVBNK; v++) begin
          map_tbl[r].pb[v] <= pbank_t'(v);
        end
        map_tbl[r].free <= pbank_t'(`MPM_NUMVBNK);
      end
    end else if (wr_clash) begin
      map_tbl[wr1_vr].pb[wr1_vb] <= map_tbl[wr1_vr].free;
      map_tbl[wr1_vr].free       <= wr1_pb; // Stale copy becomes free.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank steering.
  always_comb begin
    for (int p = 0; p < `MPM_NUMPBNK; p++) begin
      bnk_write[p]  = wr0_go && (wr0_pb == pbank_t'(p));
      bnk_wr_row[p] = wr0_vr;
      bnk_din[p]    = wr0_dat;
      if (wr1_vld && (wr1_pb_sel == pbank_t'(p))) begin
        bnk_write[p]  = 1'b1;
        bnk_wr_row[p] = wr1_vr;
        bnk_din[p]    = wr1_dat;
      end
      bnk_read[p]   = rd_req && (rd_pb == pbank_t'(p));
      bnk_rd_row[p] = rd_vr;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read return with the bank index delayed by the SRAM latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MPM_SRAM_DELAY; i++) begin
        rd_pipe_vld[i] <= 1'b0;
      end
      rd_vld <= 1'b0;
    end else begin
      rd_pipe_vld[0] <= rd_req;
      for (int i = 1; i < `MPM_SRAM_DELAY; i++) begin
        rd_pipe_vld[i] <= rd_pipe_vld[i-1];
      end
      rd_vld <= rd_pipe_vld[`MPM_SRAM_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe_bnk[0] <= rd_pb;
    for (int i = 1; i < `MPM_SRAM_DELAY; i++) begin
      rd_pipe_bnk[i] <= rd_pipe_bnk[i-1];
    end
    rd_dout <= bnk_rd_word[rd_pipe_bnk[`MPM_SRAM_DELAY-1]];
  end

endmodule

`default_nettype wire

// File: hdl/mpm_row_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpm_params.svh"

module mpm_row_align (
  input  wire                 clk,
  // Virtual row side.
  input  wire                 write,
  input  wire mpm_pkg::vrow_t wr_row,
  input  wire mpm_pkg::word_t din,
  input  wire                 read,
  input  wire mpm_pkg::vrow_t rd_row,
  // SRAM side.
  output logic                mem_write,
  output mpm_pkg::srow_t      mem_wr_adr,
  output mpm_pkg::phy_t       mem_bw,
  output mpm_pkg::phy_t       mem_din,
  output logic                mem_read,
  output mpm_pkg::srow_t      mem_rd_adr,
  input  wire mpm_pkg::phy_t  mem_dout,
  output mpm_pkg::word_t      rd_word
);

  import mpm_pkg::*;

  localparam int SLOT_W = $clog2(`MPM_NUMWRDS);

  logic [SLOT_W-1:0] wr_slot;
  logic [SLOT_W-1:0] rd_slot;
  logic [SLOT_W-1:0] rd_slot_q; // Slot of the read in flight.

  // Low row bits pick the word within the SRAM row.
  assign wr_slot = wr_row[SLOT_W-1:0];
  assign rd_slot = rd_row[SLOT_W-1:0];

  assign mem_write  = write;
  assign mem_wr_adr = srow_t'(wr_row >> SLOT_W);
  assign mem_din    = {`MPM_NUMWRDS{din}};
  assign mem_bw     = phy_t'({`MPM_WIDTH{1'b1}}) << (wr_slot * `MPM_WIDTH);

  assign mem_read   = read;
  assign mem_rd_adr = srow_t'(rd_row >> SLOT_W);

  always_ff @(posedge clk) begin
    if (read) begin
      rd_slot_q <= rd_slot;
    end
  end

  assign rd_word = mem_dout[rd_slot_q*`MPM_WIDTH +: `MPM_WIDTH];

endmodule

`default_nettype wire

// File: hdl/mpm_sram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpm_params.svh"

module mpm_sram_1r1w (
  input  wire                 clk,
  input  wire                 mem_write,
  input  wire mpm_pkg::srow_t mem_wr_adr,
  input  wire mpm_pkg::phy_t  mem_bw,
  input  wire mpm_pkg::phy_t  mem_din,
  input  wire                 mem_read,
  input  wire mpm_pkg::srow_t mem_rd_adr,
  output mpm_pkg::phy_t       mem_dout
);

  import mpm_pkg::*;

  phy_t mem [`MPM_NUMSROW];

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_wr_adr] <= (mem[mem_wr_adr] & ~mem_bw) | (mem_din & mem_bw);
    end
    if (mem_read) begin
      mem_dout <= mem[mem_rd_adr]; // Old data on a same-edge write.
    end
  end

endmodule

`default_nettype wire

// File: hdl/mpm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpm_params.svh"

module mpm_top (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 w0_cyc,
  input  wire                 w0_stb,
  input  wire mpm_pkg::addr_t w0_adr,
  input  wire mpm_pkg::word_t w0_dat,
  output logic                w0_ack,
  input  wire                 w1_cyc,
  input  wire                 w1_stb,
  input  wire mpm_pkg::addr_t w1_adr,
  input  wire mpm_pkg::word_t w1_dat,
  output logic                w1_ack,
  input  wire                 r_cyc,
  input  wire                 r_stb,
  input  wire mpm_pkg::addr_t r_adr,
  output mpm_pkg::word_t      r_dat,
  output logic                r_ack
);

  import mpm_pkg::*;

  logic  wr0_vld;
  addr_t wr0_adr;
  word_t wr0_dat;
  logic  wr1_vld;
  addr_t wr1_adr;
  word_t wr1_dat;
  logic  rd_req;
  addr_t rd_adr;
  logic  rd_vld;
  word_t rd_dout;

  logic  bnk_write   [`MPM_NUMPBNK];
  vrow_t bnk_wr_row  [`MPM_NUMPBNK];
  word_t bnk_din     [`MPM_NUMPBNK];
  logic  bnk_read    [`MPM_NUMPBNK];
  vrow_t bnk_rd_row  [`MPM_NUMPBNK];
  word_t bnk_rd_word [`MPM_NUMPBNK];

  mpm_wb_front u_front (
    .clk     (clk),
    .rst_n   (rst_n),
    .w0_cyc  (w0_cyc),
    .w0_stb  (w0_stb),
    .w0_adr  (w0_adr),
    .w0_dat  (w0_dat),
    .w0_ack  (w0_ack),
    .w1_cyc  (w1_cyc),
    .w1_stb  (w1_stb),
    .w1_adr  (w1_adr),
    .w1_dat  (w1_dat),
    .w1_ack  (w1_ack),
    .r_cyc   (r_cyc),
    .r_stb   (r_stb),
    .r_adr   (r_adr),
    .r_dat   (r_dat),
    .r_ack   (r_ack),
    .wr0_vld (wr0_vld),
    .wr0_adr (wr0_adr),
    .wr0_dat (wr0_dat),
    .wr1_vld (wr1_vld),
    .wr1_adr (wr1_adr),
    .wr1_dat (wr1_dat),
    .rd_req  (rd_req),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  mpm_bank_map u_map (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr0_vld     (wr0_vld),
    .wr0_adr     (wr0_adr),
    .wr0_dat     (wr0_dat),
    .wr1_vld     (wr1_vld),
    .wr1_adr     (wr1_adr),
    .wr1_dat     (wr1_dat),
    .rd_req      (rd_req),
    .rd_adr      (rd_adr),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .bnk_write   (bnk_write),
    .bnk_wr_row  (bnk_wr_row),
    .bnk_din     (bnk_din),
    .bnk_read    (bnk_read),
    .bnk_rd_row  (bnk_rd_row),
    .bnk_rd_word (bnk_rd_word)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Physical banks where the last one starts out as the spare.
  for (genvar b = 0; b < `MPM_NUMPBNK; b++) begin : g_bank
    logic  mem_write;
    srow_t mem_wr_adr;
    phy_t  mem_bw;
    phy_t  mem_din;
    logic  mem_read;
    srow_t mem_rd_adr;
    phy_t  mem_dout;

    mpm_row_align u_align (
      .clk        (clk),
      .write      (bnk_write[b]),
      .wr_row     (bnk_wr_row[b]),
      .din        (bnk_din[b]),
      .read       (bnk_read[b]),
      .rd_row     (bnk_rd_row[b]),
      .mem_write  (mem_write),
      .mem_wr_adr (mem_wr_adr),
      .mem_bw     (mem_bw),
      .mem_din    (mem_din),
      .mem_read   (mem_read),
      .mem_rd_adr (mem_rd_adr),
      .mem_dout   (mem_dout),
      .rd_word    (bnk_rd_word[b])
    );

    mpm_sram_1r1w u_sram (
      .clk        (clk),
      .mem_write  (mem_write),
      .mem_wr_adr (mem_wr_adr),
      .mem_bw     (mem_bw),
      .mem_din    (mem_din),
      .mem_read   (mem_read),
      .mem_rd_adr (mem_rd_adr),
      .mem_dout   (mem_dout)
    );
  end

endmodule

`default_nettype wire

// File: dv/mpm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpm_params.svh"

module mpm_tb;

  import mpm_pkg::*;

  localparam int NUM_WORDS  = `MPM_NUMVBNK * `MPM_NUMVROW;
  localparam int DRV_DLY    = 2;
  // About 2900 cycles of tests, so 4000 leaves margin.
  localparam int MAX_CYCLES = 4000;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  w0_cyc, w0_stb, w0_ack;
  addr_t w0_adr;
  word_t w0_dat;
  logic  w1_cyc, w1_stb, w1_ack;
  addr_t w1_adr;
  word_t w1_dat;
  logic  r_cyc, r_stb, r_ack;
  addr_t r_adr;
  word_t r_dat;

  word_t    model [NUM_WORDS]; // Reference memory.
  logic [1:0] w0_age, w1_age;
  logic [2:0] r_age;
  logic     exp_w0_ack, exp_w1_ack, exp_r_ack;
  word_t    exp_r_dat;
  int       cycles = 0;
  integer   seed;

  always #50 clk = ~clk;

  mpm_top DUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .w0_cyc (w0_cyc),
    .w0_stb (w0_stb),
    .w0_adr (w0_adr),
    .w0_dat (w0_dat),
    .w0_ack (w0_ack),
    .w1_cyc (w1_cyc),
    .w1_stb (w1_stb),
    .w1_adr (w1_adr),
    .w1_dat (w1_dat),
    .w1_ack (w1_ack),
    .r_cyc  (r_cyc),
    .r_stb  (r_stb),
    .r_adr  (r_adr),
    .r_dat  (r_dat),
    .r_ack  (r_ack)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1, "Check failed");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected handshake timing and reference model.
  // Write ack one cycle after the sampling edge, read ack three cycles after.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w0_age     <= 2'd0;
      w1_age     <= 2'd0;
      r_age      <= 3'd0;
      exp_w0_ack <= 1'b0;
      exp_w1_ack <= 1'b0;
      exp_r_ack  <= 1'b0;
    end else begin
      if (w0_ack) model[w0_adr] = w0_dat;
      if (w1_ack) model[w1_adr] = w1_dat; // Port 1 lands last.

      if (w0_age == 2'd0 && w0_cyc && w0_stb) w0_age <= 2'd1;
      else if (w0_age == 2'd1) begin
        w0_age     <= 2'd2;
        exp_w0_ack <= 1'b1;
      end else if (w0_age == 2'd2) begin
        w0_age     <= 2'd0;
        exp_w0_ack <= 1'b0;
      end

      if (w1_age == 2'd0 && w1_cyc && w1_stb) w1_age <= 2'd1;
      else if (w1_age == 2'd1) begin
        w1_age     <= 2'd2;
        exp_w1_ack <= 1'b1;
      end else if (w1_age == 2'd2) begin
        w1_age     <= 2'd0;
        exp_w1_ack <= 1'b0;
      end

      if (r_age == 3'd0) begin
        if (r_cyc && r_stb) begin
          r_age     <= 3'd1;
          exp_r_dat <= model[r_adr];
        end
      end else if (r_age == 3'd3) begin
        r_age     <= 3'd4;
        exp_r_ack <= 1'b1;
      end else if (r_age == 3'd4) begin
        r_age     <= 3'd0;
        exp_r_ack <= 1'b0;
      end else begin
        r_age <= r_age + 3'd1;
      end
    end
  end

  // Sampled at the falling edge, where everything is settled.
  a_w0_ack: assert property (@(negedge clk) disable iff (!rst_n) w0_ack == exp_w0_ack)
    else abort_run($sformatf("FAIL time=%0t signal=w0_ack expected=%0b actual=%0b",
                             $time, exp_w0_ack, w0_ack));
  a_w1_ack: assert property (@(negedge clk) disable iff (!rst_n) w1_ack == exp_w1_ack)
    else abort_run($sformatf("FAIL time=%0t signal=w1_ack expected=%0b actual=%0b",
                             $time, exp_w1_ack, w1_ack));
  a_r_ack: assert property (@(negedge clk) disable iff (!rst_n) r_ack == exp_r_ack)
    else abort_run($sformatf("FAIL time=%0t signal=r_ack expected=%0b actual=%0b",
                             $time, exp_r_ack, r_ack));
  a_r_dat: assert property (@(negedge clk) disable iff (!rst_n) r_ack |-> r_dat == exp_r_dat)
    else abort_run($sformatf("FAIL time=%0t signal=r_dat expected=%h actual=%h",
                             $time, exp_r_dat, r_dat));

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles.", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone masters that are called at a rising edge and return at one.
  task automatic write_port0(input addr_t adr, input word_t dat);
    #DRV_DLY;
    w0_cyc = 1'b1;
    w0_stb = 1'b1;
    w0_adr = adr;
    w0_dat = dat;
    @(posedge clk);
    #DRV_DLY;
    while (!w0_ack) begin
      @(posedge clk);
      #DRV_DLY;
    end
    w0_cyc = 1'b0;
    w0_stb = 1'b0; // Address and data stay for the model.
    @(posedge clk);
  endtask

  task automatic write_port1(input addr_t adr, input word_t dat);
    #DRV_DLY;
    w1_cyc = 1'b1;
    w1_stb = 1'b1;
    w1_adr = adr;
    w1_dat = dat;
    @(posedge clk);
    #DRV_DLY;
    while (!w1_ack) begin
      @(posedge clk);
      #DRV_DLY;
    end
    w1_cyc = 1'b0;
    w1_stb = 1'b0;
    @(posedge clk);
  endtask

  task automatic read_port(input addr_t adr);
    #DRV_DLY;
    r_cyc = 1'b1;
    r_stb = 1'b1;
    r_adr = adr;
    @(posedge clk);
    #DRV_DLY;
    while (!r_ack) begin
      @(posedge clk);
      #DRV_DLY;
    end
    r_cyc = 1'b0;
    r_stb = 1'b0;
    @(posedge clk);
  endtask

  task automatic check_all_words();
    for (int a = 0; a < NUM_WORDS; a++) begin
      read_port(addr_t'(a));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stim
    addr_t a0, a1, ra;
    word_t d0, d1;
    int    mode;

    seed   = 32'hc9b1feec;
    rst_n  = 1'b0;
    w0_cyc = 1'b0;
    w0_stb = 1'b0;
    w0_adr = '0;
    w0_dat = '0;
    w1_cyc = 1'b0;
    w1_stb = 1'b0;
    w1_adr = '0;
    w1_dat = '0;
    r_cyc  = 1'b0;
    r_stb  = 1'b0;
    r_adr  = '0;
    repeat (16) @(posedge clk);
    #DRV_DLY rst_n = 1'b1;
    repeat (4) @(posedge clk); // No ack may rise while idle.

    // Single-port writes followed by a full readback.
    for (int a = 0; a < NUM_WORDS; a++) begin
      write_port0(addr_t'(a), {16'hc0de, 10'd0, addr_t'(a)});
    end
    check_all_words();

    // Both ports at once to different virtual banks.
    for (int i = 0; i < NUM_WORDS / 2; i++) begin
      fork
        write_port0(addr_t'(2 * i), {16'h3b3b, 10'd0, addr_t'(2 * i)});
        write_port1(addr_t'(2 * i + 1), {16'h3b3b, 10'd0, addr_t'(2 * i + 1)});
      join
    end
    check_all_words();

    // Both ports hit one virtual bank in a few different rows many times.
    for (int i = 0; i < 48; i++) begin
      a0 = addr_t'((i % 3) * 4 + (i % 4));
      a1 = addr_t'((8 + (i % 3)) * 4 + (i % 4));
      if (i % 8 >= 4) begin
        ra = a0;
        a0 = a1;
        a1 = ra;
      end
      fork
        write_port0(a0, {8'h4d, 8'(i), 10'd0, a0});
        write_port1(a1, {8'h4e, 8'(i), 10'd0, a1});
      join
    end
    check_all_words();

    // Same address on both ports.
    for (int i = 0; i < 16; i++) begin
      a0 = addr_t'(i * 7);
      fork
        write_port0(a0, {16'h5500, 10'd0, a0});
        write_port1(a0, {16'haa11, 10'd0, a0});
      join
      read_port(a0);
    end

    // Random mix with reads kept off the addresses being written.
    for (int n = 0; n < 200; n++) begin
      mode = $random(seed) & 3;
      a0   = addr_t'($random(seed));
      a1   = addr_t'($random(seed));
      d0   = word_t'($random(seed));
      d1   = word_t'($random(seed));
      if (n % 4 == 0) a1 = {a1[5:2], a0[1:0]};
      if (n % 16 == 5) a1 = a0;
      do begin
        ra = addr_t'($random(seed));
      end while (ra == a0 || ra == a1);
      fork
        begin
          if (mode != 2) write_port0(a0, d0);
        end
        begin
          if (mode != 1) write_port1(a1, d1);
        end
        begin
          if (mode != 3) read_port(ra);
        end
      join
    end
    check_all_words();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/mpm_pkg.sv
hdl/mpm_wb_front.sv
hdl/mpm_bank_map.sv
hdl/mpm_row_align.sv
hdl/mpm_sram_1r1w.sv
hdl/mpm_top.sv
dv/mpm_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mpm_tb -o mpm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/mpm_sim 2>&1)
sim_status=$?
printf '%s\n' "$output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
